//--- src.f
+incdir+common
common/lsu_pkg.sv
rtl/lsu_regs.sv
rtl/req_queue.sv
rtl/mem_access.sv
rtl/data_ram.sv
rtl/lsu_top.sv
verification/tb_clock.sv
verification/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/lsu_tb.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int wait_limit = 50;

  logic                 clk;
  logic                 reset;
  logic                 req_valid;
  lsu_req_t             req;
  logic                 credit_return;
  logic                 resp_valid;
  lsu_resp_t            resp;
  logic                 cfg_write;
  cfg_reg_e             cfg_sel;
  logic [`LSU_XLEN-1:0] cfg_wdata;
  logic [`LSU_XLEN-1:0] cfg_rdata;

  // byte model of the window, indexed by offset from the current base
  logic [7:0]  ref_mem [`LSU_RAM_WORDS*8];
  logic [63:0] win_lo;
  logic [63:0] win_hi;
  logic [31:0] lfsr_state;
  lsu_resp_t   exp_q [$];
  int          sent_q [$];
  lsu_resp_t   resp_q [$];
  int          resp_cycle_q [$];
  int          cycle;
  int          credits;
  int          credit_pulses;
  int          exp_faults;
  int          checks;
  int          errors;
  int          timeouts;

  tb_clock i_tb_clock (.clk(clk));

  lsu_top i_lsu_top (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .cfg_write     (cfg_write),
    .cfg_sel       (cfg_sel),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // responses and returned credits, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (resp_valid) begin
        resp_q.push_back(resp);
        resp_cycle_q.push_back(cycle);
      end
      if (credit_return) begin
        credits++;
        credit_pulses++;
      end
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  // little-endian gather, then sign or zero extension
  function automatic logic [63:0] model_load(input mem_op_e op, input int off);
    int          nbytes;
    logic [63:0] v;
    nbytes = access_bytes(op);
    v = '0;
    for (int b = 0; b < nbytes; b++) begin
      v[b*8 +: 8] = ref_mem[off + b];
    end
    if ((op inside {op_lb, op_lh, op_lw}) && v[nbytes*8-1]) begin
      for (int b = nbytes; b < 8; b++) begin
        v[b*8 +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout: %s", what);
  endtask

  task automatic check_resp(input string name, input lsu_resp_t got, input lsu_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_credits(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // waits for a credit, predicts the response and drives one request cycle
  task automatic send_req(input mem_op_e op, input logic [63:0] addr, input logic [63:0] wdata);
    int        waited;
    int        nbytes;
    int        off;
    lsu_resp_t exp;
    waited = 0;
    while (credits == 0 && waited < wait_limit) begin
      next_cycle();
      waited++;
    end
    if (credits == 0) begin
      report_timeout("no credit came back for a new request");
    end else begin
      nbytes = access_bytes(op);
      exp.rdata = '0;
      exp.is_load = !(op inside {op_sb, op_sh, op_sw, op_sd});
      exp.error = (addr < win_lo) || (addr >= win_hi) || ((addr % 64'(nbytes)) != 0);
      off = int'(addr - win_lo);
      if (exp.error) begin
        exp_faults++;
      end else if (exp.is_load) begin
        exp.rdata = model_load(op, off);
      end else begin
        for (int b = 0; b < nbytes; b++) begin
          ref_mem[off + b] = wdata[b*8 +: 8];
        end
      end
      exp_q.push_back(exp);
      sent_q.push_back(cycle);
      req_valid = 1'b1;
      req.op = op;
      req.addr = addr;
      req.wdata = wdata;
      credits--;
      next_cycle();
      req_valid = 1'b0;
    end
  endtask

  task automatic collect_resp(output lsu_resp_t got);
    int waited;
    waited = 0;
    got = '0;
    while (resp_q.size() == 0 && waited < wait_limit) begin
      next_cycle();
      waited++;
    end
    if (resp_q.size() == 0 || exp_q.size() == 0) begin
      report_timeout("no response arrived for an outstanding request");
    end else begin
      got = resp_q.pop_front();
      check_resp("resp", got, exp_q.pop_front());
      check_latency("resp latency", resp_cycle_q.pop_front() - sent_q.pop_front(), 3);
    end
  endtask

  task automatic do_access(input mem_op_e op, input logic [63:0] addr, input logic [63:0] wdata,
                           output lsu_resp_t got);
    send_req(op, addr, wdata);
    collect_resp(got);
  endtask

  task automatic read_cfg(input cfg_reg_e sel, output logic [63:0] value);
    cfg_sel = sel;
    @(negedge clk);
    value = cfg_rdata;
    next_cycle();
  endtask

  task automatic write_cfg(input cfg_reg_e sel, input logic [63:0] value);
    cfg_write = 1'b1;
    cfg_sel = sel;
    cfg_wdata = value;
    next_cycle();
    cfg_write = 1'b0;
  endtask

  task automatic test_reset_state();
    logic [63:0] v;
    int          pulses;
    read_cfg(reg_base, v);
    check_data("cfg base", v, `LSU_RESET_BASE);
    read_cfg(reg_limit, v);
    check_data("cfg limit", v, `LSU_RESET_LIMIT);
    read_cfg(reg_faults, v);
    check_data("cfg faults", v, '0);
    pulses = credit_pulses;
    repeat (5) next_cycle();
    check_credits("credit_return while idle", credit_pulses - pulses, 0);
    check_credits("resp_valid while idle", resp_q.size(), 0);
    check_credits("credits after reset", credits, `LSU_QUEUE_DEPTH);
  endtask

  task automatic test_single_double();
    logic [63:0] data;
    lsu_resp_t   r;
    data = rand_bits(64);
    do_access(op_sd, win_lo, data, r);
    do_access(op_ld, win_lo, '0, r);
    check_data("ld rdata", r.rdata, data);
  endtask

  task automatic test_sub_word();
    mem_op_e     st_op [3];
    mem_op_e     ls_op [3];
    mem_op_e     lu_op [3];
    logic [63:0] word;
    int          nbytes;
    lsu_resp_t   r;
    st_op = '{op_sb, op_sh, op_sw};
    ls_op = '{op_lb, op_lh, op_lw};
    lu_op = '{op_lbu, op_lhu, op_lwu};
    word = win_lo + 64'h40;
    do_access(op_sd, word, rand_bits(64), r);
    for (int k = 0; k < 3; k++) begin
      nbytes = access_bytes(st_op[k]);
      for (int o = 0; o < 8; o += nbytes) begin
        do_access(st_op[k], word + 64'(o), rand_bits(64), r);
        do_access(ls_op[k], word + 64'(o), '0, r);
        do_access(lu_op[k], word + 64'(o), '0, r);
        // whole word shows the neighbors untouched
        do_access(op_ld, word, '0, r);
      end
    end
  endtask

  task automatic test_faults();
    logic [63:0] word;
    logic [63:0] v;
    lsu_resp_t   r;
    word = win_lo + 64'h80;
    write_cfg(reg_faults, '0);
    exp_faults = 0;
    do_access(op_sd, word, rand_bits(64), r);
    do_access(op_sd, win_hi - 64'd8, rand_bits(64), r);
    // misaligned for the size
    do_access(op_lh, word + 64'd1, '0, r);
    do_access(op_lw, word + 64'd2, '0, r);
    do_access(op_ld, word + 64'd4, '0, r);
    do_access(op_sh, word + 64'd3, rand_bits(64), r);
    do_access(op_sw, word + 64'd6, rand_bits(64), r);
    do_access(op_sd, word + 64'd4, rand_bits(64), r);
    // outside the window on either side
    do_access(op_ld, win_lo - 64'd8, '0, r);
    do_access(op_sb, win_lo - 64'd1, rand_bits(64), r);
    do_access(op_sd, win_hi, rand_bits(64), r);
    do_access(op_lbu, win_hi + 64'd5, '0, r);
    do_access(op_ld, win_hi - 64'd8, '0, r);
    do_access(op_ld, word, '0, r);
    read_cfg(reg_faults, v);
    check_data("fault count", v, 64'(exp_faults));
    write_cfg(reg_faults, '0);
    read_cfg(reg_faults, v);
    check_data("fault count after clear", v, '0);
  endtask

  task automatic test_credit_flow();
    logic [63:0] addr [4];
    int          pulses;
    lsu_resp_t   r;
    pulses = credit_pulses;
    // back-to-back, send_req holds off whenever the credits run out
    for (int i = 0; i < 4; i++) begin
      addr[i] = win_lo + (rand_bits(8) << 3);
      send_req(op_sd, addr[i], rand_bits(64));
    end
    for (int i = 0; i < 4; i++) begin
      send_req(op_ld, addr[i], '0);
    end
    for (int i = 0; i < 8; i++) begin
      collect_resp(r);
    end
    check_credits("credit_return pulses", credit_pulses - pulses, 8);
    check_credits("credits after burst", credits, `LSU_QUEUE_DEPTH);
  endtask

  task automatic test_window_move();
    logic [63:0] new_base;
    logic [63:0] data;
    logic [63:0] v;
    lsu_resp_t   r;
    new_base = 64'h0000_0000_9000_0000;
    write_cfg(reg_base, new_base);
    write_cfg(reg_limit, new_base + 64'(`LSU_RAM_WORDS * 8));
    win_lo = new_base;
    win_hi = new_base + 64'(`LSU_RAM_WORDS * 8);
    read_cfg(reg_base, v);
    check_data("cfg base moved", v, win_lo);
    read_cfg(reg_limit, v);
    check_data("cfg limit moved", v, win_hi);
    do_access(op_ld, `LSU_RESET_BASE, '0, r);
    data = rand_bits(64);
    do_access(op_sd, new_base, data, r);
    do_access(op_ld, new_base, '0, r);
    check_data("ld at new base", r.rdata, data);
  endtask

  initial begin
    lfsr_state = 32'd74532;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    cfg_write = 1'b0;
    cfg_sel = reg_base;
    cfg_wdata = '0;
    credits = `LSU_QUEUE_DEPTH;
    win_lo = `LSU_RESET_BASE;
    win_hi = `LSU_RESET_LIMIT;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_single_double();
    test_sub_word();
    test_faults();
    test_credit_flow();
    test_window_move();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  lsu_pkg::lsu_req_t    req,
  output logic                 credit_return,
  output logic                 resp_valid,
  output lsu_pkg::lsu_resp_t   resp,
  input  logic                 cfg_write,
  input  lsu_pkg::cfg_reg_e    cfg_sel,
  input  logic [`LSU_XLEN-1:0] cfg_wdata,
  output logic [`LSU_XLEN-1:0] cfg_rdata
);
  import lsu_pkg::*;

  // queue to access logic
  logic     issue_valid;
  lsu_req_t issue_req;

  // config window and fault pulse
  logic [`LSU_XLEN-1:0] win_base;
  logic [`LSU_XLEN-1:0] win_limit;
  logic                 fault;

  // ram port
  logic                              ram_en;
  logic [`LSU_XLEN/8-1:0]            ram_we;
  logic [$clog2(`LSU_RAM_WORDS)-1:0] ram_index;
  logic [`LSU_XLEN-1:0]              ram_wdata;
  logic [`LSU_XLEN-1:0]              ram_rdata;

  req_queue i_req_queue (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .issue_valid   (issue_valid),
    .issue_req     (issue_req),
    .credit_return (credit_return)
  );

  lsu_regs i_lsu_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_write (cfg_write),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .fault     (fault),
    .win_base  (win_base),
    .win_limit (win_limit)
  );

  mem_access i_mem_access (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .win_base    (win_base),
    .win_limit   (win_limit),
    .fault       (fault),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_index   (ram_index),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  data_ram i_data_ram (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_index (ram_index),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module data_ram (
  input  logic                              clk,
  input  logic                              ram_en,
  input  logic [`LSU_XLEN/8-1:0]            ram_we,
  input  logic [$clog2(`LSU_RAM_WORDS)-1:0] ram_index,
  input  logic [`LSU_XLEN-1:0]              ram_wdata,
  output logic [`LSU_XLEN-1:0]              ram_rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

  // byte writes, read returns the word as it was before the write
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (ram_we[b]) begin
          mem[ram_index][b*8 +: 8] <= ram_wdata[b*8 +: 8];
        end
      end
      ram_rdata <= mem[ram_index];
    end
  end

endmodule

//--- rtl/mem_access.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module mem_access (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              issue_valid,
  input  lsu_pkg::lsu_req_t                 issue_req,
  input  logic [`LSU_XLEN-1:0]              win_base,
  input  logic [`LSU_XLEN-1:0]              win_limit,
  output logic                              fault,
  output logic                              ram_en,
  output logic [`LSU_XLEN/8-1:0]            ram_we,
  output logic [$clog2(`LSU_RAM_WORDS)-1:0] ram_index,
  output logic [`LSU_XLEN-1:0]              ram_wdata,
  input  logic [`LSU_XLEN-1:0]              ram_rdata,
  output logic                              resp_valid,
  output lsu_pkg::lsu_resp_t                resp
);
  import lsu_pkg::*;

  localparam int index_w = $clog2(`LSU_RAM_WORDS);

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 2'd0;
      op_lh, op_lhu, op_sh: return 2'd1;
      op_lw, op_lwu, op_sw: return 2'd2;
      default:              return 2'd3;
    endcase
  endfunction

  function automatic logic op_is_store(input mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  function automatic logic op_is_signed(input mem_op_e op);
    return op inside {op_lb, op_lh, op_lw};
  endfunction

  logic [1:0]           size;
  logic [2:0]           offset;
  logic [2:0]           align_mask;
  logic [7:0]           size_mask;
  logic [7:0]           lane_mask;
  logic                 error;
  logic [`LSU_XLEN-1:0] addr_off;

  assign size       = op_size(issue_req.op);
  assign offset     = issue_req.addr[2:0];
  assign align_mask = (3'd1 << size) - 3'd1;
  assign error      = (|(offset & align_mask)) || (issue_req.addr < win_base) ||
                      (issue_req.addr >= win_limit);
  assign addr_off   = issue_req.addr - win_base;

  // byte lanes for the size, moved to the address offset
  always_comb begin
    case (size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end
  assign lane_mask = size_mask << offset;

  // faulting requests never reach the ram
  assign fault     = issue_valid && error;
  assign ram_en    = issue_valid && !error;
  assign ram_we    = (ram_en && op_is_store(issue_req.op)) ? lane_mask : '0;
  assign ram_index = addr_off[index_w+2:3];
  assign ram_wdata = issue_req.wdata << {offset, 3'b000};

  logic                 s1_valid;
  mem_op_e              s1_op;
  logic [2:0]           s1_offset;
  logic                 s1_error;
  logic                 s1_is_load;
  logic                 sign_ext;
  logic [`LSU_XLEN-1:0] load_word;
  logic [`LSU_XLEN-1:0] load_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      s1_valid   <= issue_valid;
      resp_valid <= s1_valid;
    end
  end

  // stage kept while the ram read is in flight
  always_ff @(posedge clk) begin
    s1_op     <= issue_req.op;
    s1_offset <= offset;
    s1_error  <= error;
  end

  assign s1_is_load = !op_is_store(s1_op);
  assign sign_ext   = op_is_signed(s1_op);
  assign load_word  = ram_rdata >> {s1_offset, 3'b000};

  // trim to size, then sign or zero extend
  always_comb begin
    case (op_size(s1_op))
      2'd0:    load_data = {{(`LSU_XLEN-8){sign_ext & load_word[7]}}, load_word[7:0]};
      2'd1:    load_data = {{(`LSU_XLEN-16){sign_ext & load_word[15]}}, load_word[15:0]};
      2'd2:    load_data = {{(`LSU_XLEN-32){sign_ext & load_word[31]}}, load_word[31:0]};
      default: load_data = load_word;
    endcase
  end

  always_ff @(posedge clk) begin
    resp.rdata   <= (s1_is_load && !s1_error) ? load_data : '0;
    resp.is_load <= s1_is_load;
    resp.error   <= s1_error;
  end

endmodule

//--- rtl/req_queue.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module req_queue (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  input  lsu_pkg::lsu_req_t req,
  output logic              issue_valid,
  output lsu_pkg::lsu_req_t issue_req,
  output logic              credit_return
);
  import lsu_pkg::*;

  localparam int ptr_w = $clog2(`LSU_QUEUE_DEPTH);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`LSU_QUEUE_DEPTH - 1);

  lsu_req_t         entries [`LSU_QUEUE_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             pop;

  // head leaves every cycle the queue holds something
  assign pop           = (count != '0);
  assign issue_valid   = pop;
  assign issue_req     = entries[rd_ptr];
  assign credit_return = pop;

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry storage
  // the credit rule keeps writes off a full queue
  always_ff @(posedge clk) begin
    if (req_valid) begin
      entries[wr_ptr] <= req;
    end
  end

endmodule

//--- rtl/lsu_regs.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module lsu_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_write,
  input  lsu_pkg::cfg_reg_e    cfg_sel,
  input  logic [`LSU_XLEN-1:0] cfg_wdata,
  output logic [`LSU_XLEN-1:0] cfg_rdata,
  input  logic                 fault,
  output logic [`LSU_XLEN-1:0] win_base,
  output logic [`LSU_XLEN-1:0] win_limit
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] fault_count;
  logic                 clear_faults;

  assign clear_faults = cfg_write && (cfg_sel == reg_faults);

  // window registers
  always_ff @(posedge clk) begin
    if (reset) begin
      win_base  <= `LSU_RESET_BASE;
      win_limit <= `LSU_RESET_LIMIT;
    end else if (cfg_write) begin
      if (cfg_sel == reg_base) begin
        win_base <= cfg_wdata;
      end
      if (cfg_sel == reg_limit) begin
        win_limit <= cfg_wdata;
      end
    end
  end

  // saturating fault counter, clear has priority
  always_ff @(posedge clk) begin
    if (reset) begin
      fault_count <= '0;
    end else if (clear_faults) begin
      fault_count <= '0;
    end else if (fault && (fault_count != '1)) begin
      fault_count <= fault_count + 1'b1;
    end
  end

  // read mux
  always_comb begin
    case (cfg_sel)
      reg_base:   cfg_rdata = win_base;
      reg_limit:  cfg_rdata = win_limit;
      reg_faults: cfg_rdata = fault_count;
      default:    cfg_rdata = '0;
    endcase
  end

endmodule

//--- common/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

  // load/store opcodes, loads first
  typedef enum logic [3:0] {
    op_lb  = 4'd0,
    op_lh  = 4'd1,
    op_lw  = 4'd2,
    op_ld  = 4'd3,
    op_lbu = 4'd4,
    op_lhu = 4'd5,
    op_lwu = 4'd6,
    op_sb  = 4'd7,
    op_sh  = 4'd8,
    op_sw  = 4'd9,
    op_sd  = 4'd10
  } mem_op_e;

  // config register select
  typedef enum logic [1:0] {
    reg_base   = 2'd0,
    reg_limit  = 2'd1,
    reg_faults = 2'd2
  } cfg_reg_e;

  // request as it enters the queue
  typedef struct packed {
    mem_op_e              op;
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] wdata;
  } lsu_req_t;

  // one response per request, in order
  // rdata is zero for stores and faulting accesses
  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    logic                 is_load;
    logic                 error;
  } lsu_resp_t;

endpackage

//--- common/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width
`define LSU_XLEN 64

// ram depth in 64-bit words, 2 KiB in total
`define LSU_RAM_WORDS 256

// request queue entries, also the credits held after reset
`define LSU_QUEUE_DEPTH 4

// address window after reset
`define LSU_RESET_BASE 64'h0000_0000_8000_0000
`define LSU_RESET_LIMIT (`LSU_RESET_BASE + `LSU_RAM_WORDS * 8)

`endif
